/* Makefile */
TOP := ucpu_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir

# Pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* sim.f */
src/ucpu_pkg.sv
src/control_decode.sv
src/alu.sv
src/bus_datapath.sv
src/branch_unit.sv
src/ucpu_core.sv
tb/tb_clock.sv
tb/ucpu_core_tb.sv

/* src/alu.sv */
`timescale 1ns/1ps
// Purely combinational and carry is only meaningful for add, so an AND result reports carry clear
module alu (
    input  logic [ucpu_pkg::data_w-1:0] x,
    input  logic [ucpu_pkg::data_w-1:0] y,
    input  logic [5:0]                  alu_ctl,     // {ex, nx, ey, ny, f, no}
    output logic [ucpu_pkg::data_w-1:0] result,
    output logic [2:0]                  flags_next   // Indexed by flag_* positions
);
    import ucpu_pkg::*;

    logic              ex;
    logic              nx;
    logic              ey;
    logic              ny;
    logic              f;
    logic              no;
    logic [data_w-1:0] x_en;   // X after enable
    logic [data_w-1:0] x_op;   // X after optional invert
    logic [data_w-1:0] y_en;
    logic [data_w-1:0] y_op;
    logic [data_w:0]   sum;    // Extra bit holds carry out
    logic [data_w-1:0] f_out;  // Before output invert

    assign {ex, nx, ey, ny, f, no} = alu_ctl;

    // Operand conditioning, zero first then invert
    assign x_en = ex ? x : '0;
    assign x_op = nx ? ~x_en : x_en;
    assign y_en = ey ? y : '0;
    assign y_op = ny ? ~y_en : y_en;

    // Single adder, widened by one for carry
    assign sum = {1'b0, x_op} + {1'b0, y_op};

    assign f_out  = f ? sum[data_w-1:0] : (x_op & y_op);
    assign result = no ? ~f_out : f_out;  // NO applies after F

    // Flags from the final word except carry
    always_comb begin
        flags_next         = '0;
        flags_next[flag_z] = (result == '0);
        flags_next[flag_c] = f & sum[data_w];  // Cleared for AND
        flags_next[flag_n] = result[data_w-1];  // Sign bit
    end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps
// Jumps test the flags held before the current cycle, and flags change only in EO cycles
module branch_unit (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       eo,          // Flag latch enable
    input  logic [2:0] flags_next,  // From the ALU
    input  logic       jc,
    input  logic       jz,
    input  logic       jgt,
    input  logic       jlt,
    output logic [2:0] flags,
    output logic       pc_load
);
    import ucpu_pkg::*;

    logic zero;
    logic carry;
    logic neg;

    // Flag register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (eo) begin
            flags <= flags_next;
        end
    end

    assign zero  = flags[flag_z];
    assign carry = flags[flag_c];
    assign neg   = flags[flag_n];

    // Any selected test that holds loads PC
    assign pc_load = (jc  & carry)
                   | (jz  & zero)
                   | (jgt & ~zero & ~neg)  // Strictly positive
                   | (jlt & neg);

    // No load without a jump bit
    a_load_needs_jump: assert property (@(posedge clk) disable iff (!arst_n)
        pc_load |-> (jc || jz || jgt || jlt))
        else $error("branch_unit: PC load without jump bit");

endmodule

/* src/bus_datapath.sv */
`timescale 1ns/1ps
// RAM has 2^ram_aw words addressed by the low MAR bits with ram_aw at most 16, reads are asynchronous
module bus_datapath #(
    parameter int ram_aw = 8
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        eo,          // ALU result owns the bus
    input  logic                        pc_oe,
    input  logic                        irh_oe,
    input  logic                        irl_oe,
    input  logic                        ram_oe,
    input  logic                        x_oe,
    input  logic                        y_oe,
    input  logic                        dev_oe,
    input  logic                        pa,          // PC increment
    input  logic                        mar_we,
    input  logic                        ir_we,
    input  logic                        ram_we,
    input  logic                        x_we,
    input  logic                        y_we,
    input  logic                        dev_we,
    input  logic [ucpu_pkg::data_w-1:0] alu_result,
    input  logic [ucpu_pkg::data_w-1:0] dev_in,
    input  logic                        pc_load,     // Taken jump
    output logic [ucpu_pkg::data_w-1:0] x,
    output logic [ucpu_pkg::data_w-1:0] y,
    output logic [ucpu_pkg::data_w-1:0] pc,
    output logic [ucpu_pkg::data_w-1:0] dev_out,
    output logic                        dev_out_valid,
    output logic [ucpu_pkg::data_w-1:0] bus
);
    import ucpu_pkg::*;

    localparam int ram_words = 1 << ram_aw;
    localparam int half_w    = data_w / 2;  // IR byte width

    logic [data_w-1:0] mar;
    logic [data_w-1:0] ir;
    logic [data_w-1:0] ram [ram_words];  // No reset on storage
    logic [ram_aw-1:0] ram_addr;

    assign ram_addr = mar[ram_aw-1:0];  // Upper MAR bits ignored

    // Bus multiplexer
    always_comb begin
        if (eo) begin
            bus = alu_result;
        end else if (pc_oe) begin
            bus = pc;
        end else if (irh_oe) begin
            bus = {{half_w{1'b0}}, ir[data_w-1:half_w]};  // Zero-extended high byte
        end else if (irl_oe) begin
            bus = {{half_w{1'b0}}, ir[half_w-1:0]};
        end else if (ram_oe) begin
            bus = ram[ram_addr];
        end else if (x_oe) begin
            bus = x;
        end else if (y_oe) begin
            bus = y;
        end else if (dev_oe) begin
            bus = dev_in;
        end else begin
            bus = '0;  // Spare code or idle bus
        end
    end

    // General registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar <= '0;
            ir  <= '0;
            x   <= '0;
            y   <= '0;
        end else begin
            if (mar_we) mar <= bus;
            if (ir_we)  ir  <= bus;
            if (x_we)   x   <= bus;
            if (y_we)   y   <= bus;
        end
    end

    // Jump load beats P+
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= bus;
        end else if (pa) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_we) ram[ram_addr] <= bus;
    end

    // Device output with one-cycle valid pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dev_out       <= '0;
            dev_out_valid <= 1'b0;
        end else begin
            dev_out_valid <= dev_we;
            if (dev_we) dev_out <= bus;
        end
    end

    // PC takes the jump target even when P+ is also set
    a_pc_jump: assert property (@(posedge clk) disable iff (!arst_n)
        pc_load |=> (pc == $past(bus)))
        else $error("bus_datapath: PC missed jump target");

endmodule

/* src/control_decode.sv */
`timescale 1ns/1ps
// Combinational decode only, and source strobes, RT and P+ are held low whenever EO is set
module control_decode (
    input  ucpu_pkg::uinstr_t uinstr,
    output logic              eo,
    output logic              pc_oe,
    output logic              irh_oe,
    output logic              irl_oe,
    output logic              ram_oe,
    output logic              x_oe,
    output logic              y_oe,
    output logic              dev_oe,
    output logic              rt,
    output logic              pa,
    output logic              mar_we,
    output logic              ir_we,
    output logic              ram_we,
    output logic              x_we,
    output logic              y_we,
    output logic              dev_we,
    output logic              jc,
    output logic              jz,
    output logic              jgt,
    output logic              jlt,
    output logic [5:0]        alu_ctl
);
    import ucpu_pkg::*;

    logic [2:0] bus_out;  // Source code, valid only in bus view
    logic       src_en;   // Low in ALU cycles
    logic [2:0] bus_in;   // Sink code, same bits in both views
    logic [6:0] srcs;     // Gathered for checking
    logic [5:0] snks;

    assign eo = uinstr.alu_view.eo;  // Same bit in both views

    // Sink and jump fields sit at the same bits in both views
    assign bus_in = uinstr.bus_view.bus_in;
    assign {jc, jz, jgt, jlt} = {uinstr.bus_view.jc, uinstr.bus_view.jz,
                                 uinstr.bus_view.jgt, uinstr.bus_view.jlt};

    // Pick fields through the view bit 15 selects
    always_comb begin
        if (eo) begin
            alu_ctl = {uinstr.alu_view.ex, uinstr.alu_view.nx,
                       uinstr.alu_view.ey, uinstr.alu_view.ny,
                       uinstr.alu_view.f,  uinstr.alu_view.no};
            src_en  = 1'b0;               // ALU owns the bus
            bus_out = src_pc;             // Don't care, masked by src_en
            rt      = 1'b0;
            pa      = 1'b0;
        end else begin
            alu_ctl = '0;                 // ALU idle, result unused
            src_en  = 1'b1;
            bus_out = uinstr.bus_view.bus_out;
            rt      = uinstr.bus_view.rt;
            pa      = uinstr.bus_view.pa;
        end
    end

    // Source strobes
    assign pc_oe  = src_en && (bus_out == src_pc);
    assign irh_oe = src_en && (bus_out == src_ir_hi);  // IR high byte
    assign irl_oe = src_en && (bus_out == src_ir_lo);  // IR low byte
    assign ram_oe = src_en && (bus_out == src_ram);
    assign x_oe   = src_en && (bus_out == src_x);
    assign y_oe   = src_en && (bus_out == src_y);
    assign dev_oe = src_en && (bus_out == src_dev);

    // Sink strobes apply in both views
    assign mar_we = (bus_in == snk_mar);
    assign ir_we  = (bus_in == snk_ir);
    assign ram_we = (bus_in == snk_ram);
    assign x_we   = (bus_in == snk_x);
    assign y_we   = (bus_in == snk_y);
    assign dev_we = (bus_in == snk_dev);

    assign srcs = {pc_oe, irh_oe, irl_oe, ram_oe, x_oe, y_oe, dev_oe};
    assign snks = {mar_we, ir_we, ram_we, x_we, y_we, dev_we};

    // One driver and one writer at most
    always_comb begin
        assert ($onehot0(srcs)) else $error("control_decode: several bus sources");
        assert ($onehot0(snks)) else $error("control_decode: several bus sinks");
    end

endmodule

/* src/ucpu_core.sv */
`timescale 1ns/1ps
// Core without sequencer or microcode store, so one microinstruction must arrive every clock
module ucpu_core #(
    parameter int ram_aw = 8  // RAM depth is 2^ram_aw
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [ucpu_pkg::data_w-1:0] uinstr,
    input  logic [ucpu_pkg::data_w-1:0] dev_in,
    output logic [ucpu_pkg::data_w-1:0] pc,
    output logic [ucpu_pkg::data_w-1:0] dev_out,
    output logic                        dev_out_valid,
    output logic                        rt_pulse,
    output logic [2:0]                  flags
);
    import ucpu_pkg::*;

    logic              eo;
    logic              pc_oe;
    logic              irh_oe;
    logic              irl_oe;
    logic              ram_oe;
    logic              x_oe;
    logic              y_oe;
    logic              dev_oe;
    logic              rt;
    logic              pa;
    logic              mar_we;
    logic              ir_we;
    logic              ram_we;
    logic              x_we;
    logic              y_we;
    logic              dev_we;
    logic              jc;
    logic              jz;
    logic              jgt;
    logic              jlt;
    logic [5:0]        alu_ctl;
    logic [data_w-1:0] x;          // Operand registers to ALU
    logic [data_w-1:0] y;
    logic [data_w-1:0] alu_result;
    logic [2:0]        flags_next;
    logic              pc_load;
    logic [data_w-1:0] bus;

    // Decode
    control_decode u_control_decode (
        .uinstr (uinstr),
        .eo     (eo),
        .pc_oe  (pc_oe),
        .irh_oe (irh_oe),
        .irl_oe (irl_oe),
        .ram_oe (ram_oe),
        .x_oe   (x_oe),
        .y_oe   (y_oe),
        .dev_oe (dev_oe),
        .rt     (rt),
        .pa     (pa),
        .mar_we (mar_we),
        .ir_we  (ir_we),
        .ram_we (ram_we),
        .x_we   (x_we),
        .y_we   (y_we),
        .dev_we (dev_we),
        .jc     (jc),
        .jz     (jz),
        .jgt    (jgt),
        .jlt    (jlt),
        .alu_ctl(alu_ctl)
    );

    // Execute
    alu u_alu (
        .x         (x),
        .y         (y),
        .alu_ctl   (alu_ctl),
        .result    (alu_result),
        .flags_next(flags_next)
    );

    bus_datapath #(
        .ram_aw(ram_aw)
    ) u_bus_datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .eo           (eo),
        .pc_oe        (pc_oe),
        .irh_oe       (irh_oe),
        .irl_oe       (irl_oe),
        .ram_oe       (ram_oe),
        .x_oe         (x_oe),
        .y_oe         (y_oe),
        .dev_oe       (dev_oe),
        .pa           (pa),
        .mar_we       (mar_we),
        .ir_we        (ir_we),
        .ram_we       (ram_we),
        .x_we         (x_we),
        .y_we         (y_we),
        .dev_we       (dev_we),
        .alu_result   (alu_result),
        .dev_in       (dev_in),
        .pc_load      (pc_load),
        .x            (x),
        .y            (y),
        .pc           (pc),
        .dev_out      (dev_out),
        .dev_out_valid(dev_out_valid),
        .bus          (bus)
    );

    // Result
    branch_unit u_branch_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .eo        (eo),
        .flags_next(flags_next),
        .jc        (jc),
        .jz        (jz),
        .jgt       (jgt),
        .jlt       (jlt),
        .flags     (flags),
        .pc_load   (pc_load)
    );

    // RT shows one cycle late
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rt_pulse <= 1'b0;
        end else begin
            rt_pulse <= rt;
        end
    end

    // Device word is the bus value of the writing cycle, ALU cycles included
    a_dev_word: assert property (@(posedge clk) disable iff (!arst_n)
        dev_we |=> (dev_out_valid && dev_out == $past(bus)))
        else $error("ucpu_core: device write lost");

endmodule

/* src/ucpu_pkg.sv */
// Word width is fixed at 16 by the microinstruction format and flag vectors are ordered {n, c, z}
package ucpu_pkg;

    parameter int data_w = 16;  // Datapath and microinstruction width

    // Bus source codes in the bus view, code 7 unused
    localparam logic [2:0] src_pc    = 3'd0;
    localparam logic [2:0] src_ir_hi = 3'd1;
    localparam logic [2:0] src_ir_lo = 3'd2;
    localparam logic [2:0] src_ram   = 3'd3;
    localparam logic [2:0] src_x     = 3'd4;
    localparam logic [2:0] src_y     = 3'd5;
    localparam logic [2:0] src_dev   = 3'd6;

    // Bus sink codes, shared by both views
    localparam logic [2:0] snk_none  = 3'd0;  // Nobody listens
    localparam logic [2:0] snk_mar   = 3'd1;
    localparam logic [2:0] snk_ir    = 3'd2;
    localparam logic [2:0] snk_ram   = 3'd3;
    localparam logic [2:0] snk_x     = 3'd4;
    localparam logic [2:0] snk_y     = 3'd5;
    localparam logic [2:0] snk_dev   = 3'd6;

    // Flag vector bit positions
    localparam int flag_z = 0;
    localparam int flag_c = 1;
    localparam int flag_n = 2;

    // Word as read when bit 15 is set
    typedef struct packed {
        logic       eo;      // ALU result onto bus
        logic       ex;      // Enable X
        logic       nx;      // Invert X
        logic       ey;      // Enable Y
        logic       ny;      // Invert Y
        logic       f;       // Add when set, AND when clear
        logic       no;      // Invert output
        logic [2:0] bus_in;  // Sink code
        logic       jc;
        logic       jz;
        logic       jgt;
        logic       jlt;
        logic [1:0] spare;
    } alu_view_t;

    // Word as read when bit 15 is clear
    typedef struct packed {
        logic       eo;
        logic [2:0] bus_out;  // Source code
        logic       rt;       // Return pulse request
        logic       pa;       // PC increment
        logic       spare_hi;
        logic [2:0] bus_in;
        logic       jc;
        logic       jz;
        logic       jgt;
        logic       jlt;
        logic [1:0] spare;
    } bus_view_t;

    typedef union packed {
        alu_view_t alu_view;
        bus_view_t bus_view;
    } uinstr_t;

endpackage

/* tb/tb_clock.sv */
`timescale 1ns/1ps
// Clock runs from time zero; reset is released a quarter period after the last reset edge
module tb_clock #(
    parameter int period     = 40,  // ns
    parameter int rst_cycles = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release between edges so no flop sees it mid-edge
    initial begin
        arst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #(period / 4) arst_n = 1'b1;
    end

endmodule

/* tb/ucpu_core_tb.sv */
`timescale 1ns/1ps
// Table rows are built at time zero; each row is checked one cycle after it is driven, RAM 256 words
module ucpu_core_tb;
    import ucpu_pkg::*;

    localparam int clk_period = 40;
    localparam int drive_dly  = 2;    // ns after rising edge
    localparam int check_dly  = 1;    // Registers settled, next row not yet driven
    localparam int max_rows   = 128;
    localparam logic [5:0] alu_codes [8] = '{6'b101010, 6'b101000, 6'b000010, 6'b111010,
                                              6'b101110, 6'b101011, 6'b111111, 6'b110111};
    localparam logic [5:0] flag_codes [4] = '{6'b000010,   // Zero
                                               6'b010010,   // All ones, negative
                                               6'b010110,   // Carry and negative
                                               6'b010111};  // Carry, small positive

    logic        clk;
    logic        arst_n;
    logic [15:0] uinstr;
    logic [15:0] dev_in;
    logic [15:0] pc;
    logic [15:0] dev_out;
    logic        dev_out_valid;
    logic        rt_pulse;
    logic [2:0]  flags;

    // Stimulus and expectations, one entry per microinstruction
    int          row_test  [max_rows];
    logic [15:0] row_ui    [max_rows];
    logic [15:0] row_din   [max_rows];
    logic [15:0] row_pc    [max_rows];
    logic [15:0] row_dev   [max_rows];
    logic        row_valid [max_rows];
    logic        row_rt    [max_rows];
    logic [2:0]  row_flags [max_rows];
    int          n_rows;
    logic        table_ready;

    // Expected architectural state while the table is built
    logic [15:0] m_pc;
    logic [15:0] m_dev;
    logic [2:0]  m_flags;
    logic [31:0] lfsr_state;

    string test_name   [7];
    int    test_errors [7];
    int    error_count;
    int    tests_run;
    int    tests_failed;

    tb_clock #(.period(clk_period), .rst_cycles(8)) u_tb_clock (.clk(clk), .arst_n(arst_n));

    ucpu_core #(.ram_aw(8)) u_ucpu_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .uinstr       (uinstr),
        .dev_in       (dev_in),
        .pc           (pc),
        .dev_out      (dev_out),
        .dev_out_valid(dev_out_valid),
        .rt_pulse     (rt_pulse),
        .flags        (flags)
    );

    // Bus view word; jmp is {jc, jz, jgt, jlt}
    function automatic logic [15:0] bus_op(input logic [2:0] src, input logic [2:0] snk,
                                           input logic rt, input logic pa, input logic [3:0] jmp);
        return {1'b0, src, rt, pa, 1'b0, snk, jmp, 2'b00};
    endfunction

    function automatic logic [15:0] alu_op(input logic [5:0] ctl, input logic [2:0] snk,
                                           input logic [3:0] jmp);
        return {1'b1, ctl, snk, jmp, 2'b00};
    endfunction

    // Returns {n, c, z, result}
    function automatic logic [18:0] alu_model(input logic [15:0] a, input logic [15:0] b,
                                              input logic [5:0] ctl);
        logic [15:0] xa;
        logic [15:0] yb;
        logic [16:0] s;
        logic [15:0] r;
        logic        c;
        xa = ctl[5] ? a : 16'h0000;  // ex
        if (ctl[4]) xa = ~xa;        // nx
        yb = ctl[3] ? b : 16'h0000;
        if (ctl[2]) yb = ~yb;
        s = {1'b0, xa} + {1'b0, yb};
        if (ctl[1]) begin
            r = s[15:0];
            c = s[16];
        end else begin
            r = xa & yb;
            c = 1'b0;                // No carry from AND
        end
        if (ctl[0]) r = ~r;
        return {r[15], c, (r == 16'h0000), r};
    endfunction

    function automatic logic jump_taken(input logic [2:0] f, input logic [3:0] jmp);
        return (jmp[3] & f[flag_c]) | (jmp[2] & f[flag_z])
             | (jmp[1] & ~f[flag_z] & ~f[flag_n]) | (jmp[0] & f[flag_n]);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Taps 32, 22, 2, 1
    endfunction

    // One LFSR step per bit
    task automatic draw_word(output logic [15:0] w);
        w = 16'h0000;
        for (int k = 0; k < 16; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
    endtask

    // Captures current expected state as the outcome of this row
    task automatic add_row(input int test, input logic [15:0] ui, input logic [15:0] din,
                           input logic valid, input logic rt);
        row_test[n_rows]  = test;
        row_ui[n_rows]    = ui;
        row_din[n_rows]   = din;
        row_pc[n_rows]    = m_pc;
        row_dev[n_rows]   = m_dev;
        row_valid[n_rows] = valid;
        row_rt[n_rows]    = rt;
        row_flags[n_rows] = m_flags;
        n_rows++;
    endtask

    task automatic build_table();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] t;
        logic [18:0] res;
        logic [3:0]  jmp;
        // 1: idle cycles straight after reset
        add_row(1, 16'h0000, 16'h0000, 1'b0, 1'b0);
        add_row(1, 16'h0000, 16'h5a5a, 1'b0, 1'b0);  // Source PC, no sink
        // 2: X and Y round trip through the device port
        draw_word(a);
        draw_word(b);
        add_row(2, bus_op(src_dev, snk_x, 1'b0, 1'b0, 4'h0), a, 1'b0, 1'b0);
        add_row(2, bus_op(src_dev, snk_y, 1'b0, 1'b0, 4'h0), b, 1'b0, 1'b0);
        m_dev = a;
        add_row(2, bus_op(src_x, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        m_dev = b;
        add_row(2, bus_op(src_y, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        add_row(2, 16'h0000, 16'h0000, 1'b0, 1'b0);  // Valid drops again
        // 3: ALU codes on two operand pairs, result straight to device
        for (int p = 0; p < 2; p++) begin
            draw_word(a);
            draw_word(b);
            add_row(3, bus_op(src_dev, snk_x, 1'b0, 1'b0, 4'h0), a, 1'b0, 1'b0);
            add_row(3, bus_op(src_dev, snk_y, 1'b0, 1'b0, 4'h0), b, 1'b0, 1'b0);
            for (int k = 0; k < 8; k++) begin
                res     = alu_model(a, b, alu_codes[k]);
                m_dev   = res[15:0];
                m_flags = res[18:16];
                add_row(3, alu_op(alu_codes[k], snk_dev, 4'h0), 16'h0000, 1'b1, 1'b0);
            end
        end
        // 4: two RAM words written, then read back
        draw_word(a);
        draw_word(b);
        draw_word(t);
        add_row(4, bus_op(src_dev, snk_mar, 1'b0, 1'b0, 4'h0), t, 1'b0, 1'b0);
        add_row(4, bus_op(src_dev, snk_ram, 1'b0, 1'b0, 4'h0), a, 1'b0, 1'b0);
        add_row(4, bus_op(src_dev, snk_mar, 1'b0, 1'b0, 4'h0), t + 16'd1, 1'b0, 1'b0);
        add_row(4, bus_op(src_dev, snk_ram, 1'b0, 1'b0, 4'h0), b, 1'b0, 1'b0);
        add_row(4, bus_op(src_dev, snk_mar, 1'b0, 1'b0, 4'h0), t, 1'b0, 1'b0);
        m_dev = a;
        add_row(4, bus_op(src_ram, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        add_row(4, bus_op(src_dev, snk_mar, 1'b0, 1'b0, 4'h0), t + 16'd1, 1'b0, 1'b0);
        m_dev = b;
        add_row(4, bus_op(src_ram, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        // 5: each jump bit against four flag states
        for (int s = 0; s < 4; s++) begin
            res     = alu_model(16'h0000, 16'h0000, flag_codes[s]);
            m_flags = res[18:16];
            add_row(5, alu_op(flag_codes[s], snk_none, 4'h0), 16'h0000, 1'b0, 1'b0);
            for (int j = 0; j < 4; j++) begin
                jmp = 4'b1000 >> j;
                draw_word(t);
                if (jump_taken(m_flags, jmp)) begin
                    m_pc = t;                // Load wins over P+
                end else begin
                    m_pc = m_pc + 16'd1;
                end
                add_row(5, bus_op(src_dev, snk_none, 1'b0, 1'b1, jmp), t, 1'b0, 1'b0);
            end
        end
        m_dev = m_pc;                        // PC as bus source
        add_row(5, bus_op(src_pc, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        // 6: IR bytes zero-extended, then the RT pulse
        draw_word(a);
        m_pc = m_pc + 16'd1;
        add_row(6, bus_op(src_dev, snk_ir, 1'b0, 1'b1, 4'h0), a, 1'b0, 1'b0);
        m_dev = {8'h00, a[15:8]};
        add_row(6, bus_op(src_ir_hi, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        m_dev = {8'h00, a[7:0]};
        add_row(6, bus_op(src_ir_lo, snk_dev, 1'b0, 1'b0, 4'h0), 16'h0000, 1'b1, 1'b0);
        add_row(6, bus_op(src_pc, snk_none, 1'b1, 1'b0, 4'h0), 16'h0000, 1'b0, 1'b1);
        add_row(6, 16'h0000, 16'h0000, 1'b0, 1'b0);  // Pulse gone
    endtask

    task automatic report_test(input int t);
        tests_run++;
        if (test_errors[t] == 0) begin
            $display("test %0d %s: pass", t, test_name[t]);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", t, test_name[t], test_errors[t]);
        end
    endtask

    task automatic check_row(input int i);
        int t;
        int e0;
        t  = row_test[i];
        e0 = error_count;
        assert (pc === row_pc[i]) else begin
            $display("error: row %0d pc got %h expected %h", i, pc, row_pc[i]);
            error_count++;
        end
        assert (dev_out === row_dev[i]) else begin
            $display("error: row %0d dev_out got %h expected %h", i, dev_out, row_dev[i]);
            error_count++;
        end
        assert (dev_out_valid === row_valid[i]) else begin
            $display("error: row %0d dev_out_valid got %h expected %h", i, dev_out_valid,
                     row_valid[i]);
            error_count++;
        end
        assert (rt_pulse === row_rt[i]) else begin
            $display("error: row %0d rt_pulse got %h expected %h", i, rt_pulse, row_rt[i]);
            error_count++;
        end
        assert (flags === row_flags[i]) else begin
            $display("error: row %0d flags got %h expected %h", i, flags, row_flags[i]);
            error_count++;
        end
        test_errors[t] += error_count - e0;
        if (i == n_rows - 1 || row_test[i + 1] != t) report_test(t);  // Last row of its test
    endtask

    // Stops a stuck run
    initial begin
        wait (table_ready === 1'b1);
        #((n_rows + 20) * clk_period);
        $display("timeout: the row loop did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        uinstr       = 16'h0000;
        dev_in       = 16'h0000;
        table_ready  = 1'b0;
        n_rows       = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_pc         = 16'h0000;
        m_dev        = 16'h0000;
        m_flags      = 3'b000;
        lfsr_state   = 32'hc6b6_4db0;
        test_name[1] = "reset state";
        test_name[2] = "register round trip";
        test_name[3] = "alu functions";
        test_name[4] = "ram write and read";
        test_name[5] = "branching";
        test_name[6] = "ir bytes and rt";
        build_table();
        table_ready = 1'b1;
        wait (arst_n === 1'b1);
        // Row i driven after edge k, checked after edge k+1
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            #check_dly;
            if (i > 0) check_row(i - 1);
            #(drive_dly - check_dly);
            if (i < n_rows) begin
                uinstr = row_ui[i];
                dev_in = row_din[i];
            end else begin
                uinstr = 16'h0000;           // Idle after the table
                dev_in = 16'h0000;
            end
        end
        $display("summary: %0d tests run, %0d failed, %0d errors over %0d rows",
                 tests_run, tests_failed, error_count, n_rows);
        if (tests_failed == 0 && error_count == 0 && tests_run == 6) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
